//--- lsu_pkg.sv
package lsu_pkg;

    // data path and address width
    localparam int XLEN = 64;
    // instruction word width
    localparam int INST_LEN = 32;

    // bytes per doubleword
    localparam int BYTES = XLEN / 8;
    // byte offset bits inside a doubleword
    localparam int OFS_W = $clog2(BYTES);

    // major opcodes, instr bits 6..2
    localparam logic [4:0] OPC_LOAD = 5'b00000;
    localparam logic [4:0] OPC_STORE = 5'b01000;
    // bits 1..0 of every 32-bit encoding
    localparam logic [1:0] OPC_LOW = 2'b11;

    // addi x0, x0, 0
    localparam logic [INST_LEN-1:0] INSTR_NOP = 32'h0000_0013;

    // load funct3
    localparam logic [2:0] MEMOP_LB = 3'b000;
    localparam logic [2:0] MEMOP_LH = 3'b001;
    localparam logic [2:0] MEMOP_LW = 3'b010;
    localparam logic [2:0] MEMOP_LD = 3'b011;
    localparam logic [2:0] MEMOP_LBU = 3'b100;
    localparam logic [2:0] MEMOP_LHU = 3'b101;
    localparam logic [2:0] MEMOP_LWU = 3'b110;

    // store funct3
    localparam logic [2:0] MEMOP_SB = 3'b000;
    localparam logic [2:0] MEMOP_SH = 3'b001;
    localparam logic [2:0] MEMOP_SW = 3'b010;
    localparam logic [2:0] MEMOP_SD = 3'b011;

    // cycles from accepted request to response strobe
    localparam int SRAM_LAT = 2;
    // countdown width, must hold SRAM_LAT
    localparam int LAT_W = $clog2(SRAM_LAT + 1);
    // doublewords in the data sram
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // decoder to lsu, wr_data already forwarded
    typedef struct packed {
        logic            rden;
        logic            wren;
        logic [2:0]      memop;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wr_data;
    } ls_req_t;

    // lsu to sram, wr_data already in its byte lane
    typedef struct packed {
        logic             rd_en;
        logic             wr_en;
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  wr_data;
        logic [BYTES-1:0] wr_mask;
    } sram_req_t;

    // sram to lsu, strobes are one cycle wide
    typedef struct packed {
        logic            rd_data_valid;
        logic            wr_data_ok;
        logic [XLEN-1:0] rd_data;
    } sram_rsp_t;

endpackage

//--- ls_decode.sv
`timescale 1ns/100ps

module ls_decode (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic [lsu_pkg::INST_LEN-1:0] instr_i,
    input  logic [lsu_pkg::XLEN-1:0]     addr_i,
    input  logic [lsu_pkg::XLEN-1:0]     rs2_i,
    input  logic [lsu_pkg::XLEN-1:0]     ls_res_i,
    input  logic                         ls_not_ok_i,
    output lsu_pkg::ls_req_t             ls_req_o
);
    import lsu_pkg::*;

    // previous instruction and its load result
    logic [INST_LEN-1:0] instr_last_q;
    logic [XLEN-1:0]     load_data_q;

    logic       is_load;
    logic       is_store;
    logic       last_is_load;
    logic [4:0] last_rd;
    logic [4:0] cur_rs2;
    logic       fwd_en;

    // full 7-bit opcode match
    assign is_load = (instr_i[6:2] == OPC_LOAD) && (instr_i[1:0] == OPC_LOW);
    assign is_store = (instr_i[6:2] == OPC_STORE) && (instr_i[1:0] == OPC_LOW);

    assign last_is_load = (instr_last_q[6:2] == OPC_LOAD) && (instr_last_q[1:0] == OPC_LOW);
    assign last_rd = instr_last_q[11:7];
    assign cur_rs2 = instr_i[24:20];

    // store data depends on the load just before it
    // x0 is never a real destination
    assign fwd_en = is_store && last_is_load && (last_rd == cur_rs2) && (last_rd != 5'd0);

    // instruction retires when the stall level is low
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            instr_last_q <= INSTR_NOP;
        end else if (!ls_not_ok_i) begin
            instr_last_q <= instr_i;
        end
    end

    // load result is only nonzero in the load's response cycle
    always_ff @(posedge clk) begin
        if (!ls_not_ok_i) begin
            load_data_q <= ls_res_i;
        end
    end

    always_comb begin
        ls_req_o.rden = is_load;
        ls_req_o.wren = is_store;
        // funct3
        ls_req_o.memop = instr_i[14:12];
        ls_req_o.addr = addr_i;
        // forwarded value replaces the stale register read
        ls_req_o.wr_data = fwd_en ? load_data_q : rs2_i;
    end

endmodule

//--- lsu.sv
`timescale 1ns/100ps

module lsu (
    input  logic                     clk,
    input  logic                     rstn,
    input  lsu_pkg::ls_req_t         ls_req_i,
    input  lsu_pkg::sram_rsp_t       sram_rsp_i,
    output lsu_pkg::sram_req_t       sram_req_o,
    output logic [lsu_pkg::XLEN-1:0] ls_res_o,
    output logic                     ls_not_ok_o
);
    import lsu_pkg::*;

    // high for one cycle after any response
    logic             ls_ok_q;
    logic             rsp_done;
    logic [OFS_W-1:0] byte_ofs;
    logic [5:0]       bit_ofs;
    logic [BYTES-1:0] size_mask;
    logic [XLEN-1:0]  rd_lane;
    logic [XLEN-1:0]  rd_ext;
    logic             rd_done;
    logic             wr_done;

    // byte offset within the doubleword
    assign byte_ofs = ls_req_i.addr[OFS_W-1:0];
    assign bit_ofs = {byte_ofs, 3'b000};

    assign rd_done = sram_rsp_i.rd_data_valid;
    assign wr_done = sram_rsp_i.wr_data_ok;
    assign rsp_done = rd_done | wr_done;

    // set by a response, dropped one cycle later
    // masks the enable of the next instruction in its first cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ls_ok_q <= 1'b0;
        end else begin
            ls_ok_q <= rsp_done;
        end
    end

    // access size as a right-aligned byte mask
    always_comb begin
        size_mask = '0;
        if (ls_req_i.wren) begin
            case (ls_req_i.memop)
                MEMOP_SB: size_mask = 8'h01;
                MEMOP_SH: size_mask = 8'h03;
                MEMOP_SW: size_mask = 8'h0f;
                MEMOP_SD: size_mask = 8'hff;
                default:  size_mask = '0;
            endcase
        end
    end

    always_comb begin
        // request levels gated by the completion flag
        sram_req_o.rd_en = ls_req_i.rden & ~ls_ok_q;
        sram_req_o.wr_en = ls_req_i.wren & ~ls_ok_q;
        // sram drops the offset bits itself
        sram_req_o.addr = ls_req_i.addr;
        // move store data into its byte lane
        sram_req_o.wr_data = ls_req_i.wr_data << bit_ofs;
        // mask follows the data lane
        sram_req_o.wr_mask = size_mask << byte_ofs;
    end

    // addressed bytes down to bit 0
    assign rd_lane = sram_rsp_i.rd_data >> bit_ofs;

    // sign or zero extension by load type
    always_comb begin
        case (ls_req_i.memop)
            MEMOP_LB: begin
                rd_ext = {{(XLEN-8){rd_lane[7]}}, rd_lane[7:0]};
            end
            MEMOP_LBU: begin
                rd_ext = {{(XLEN-8){1'b0}}, rd_lane[7:0]};
            end
            MEMOP_LH: begin
                rd_ext = {{(XLEN-16){rd_lane[15]}}, rd_lane[15:0]};
            end
            MEMOP_LHU: begin
                rd_ext = {{(XLEN-16){1'b0}}, rd_lane[15:0]};
            end
            MEMOP_LW: begin
                rd_ext = {{(XLEN-32){rd_lane[31]}}, rd_lane[31:0]};
            end
            MEMOP_LWU: begin
                rd_ext = {{(XLEN-32){1'b0}}, rd_lane[31:0]};
            end
            MEMOP_LD: begin
                rd_ext = rd_lane;
            end
            default: begin
                rd_ext = '0;
            end
        endcase
    end

    // zero unless a load completes this cycle
    assign ls_res_o = (ls_req_i.rden && rd_done) ? rd_ext : '0;

    // stall until the strobe that matches the request type
    assign ls_not_ok_o = (ls_req_i.rden & ~rd_done) | (ls_req_i.wren & ~wr_done);

endmodule

//--- data_sram.sv
`timescale 1ns/100ps

module data_sram (
    input  logic               clk,
    input  logic               rstn,
    input  lsu_pkg::sram_req_t sram_req_i,
    output lsu_pkg::sram_rsp_t sram_rsp_o
);
    import lsu_pkg::*;

    // doubleword storage
    logic [XLEN-1:0] mem [MEM_WORDS];

    // cycles left until the response, zero when idle
    logic [LAT_W-1:0] cnt_q;
    // kind of the captured request
    logic             rd_q;
    logic             wr_q;
    // captured request payload
    logic [MEM_IDX_W-1:0] idx_q;
    logic [XLEN-1:0]      wdata_q;
    logic [BYTES-1:0]     wmask_q;

    logic idle;
    logic accept;
    logic rsp_cycle;

    assign idle = (cnt_q == '0);
    // enables are ignored while busy
    assign accept = idle & (sram_req_i.rd_en | sram_req_i.wr_en);
    // last count is the response cycle
    assign rsp_cycle = (cnt_q == LAT_W'(1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt_q <= '0;
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else if (accept) begin
            cnt_q <= LAT_W'(SRAM_LAT);
            rd_q <= sram_req_i.rd_en;
            wr_q <= sram_req_i.wr_en;
        end else if (!idle) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // doubleword index from addr bits 10..3
    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q <= sram_req_i.addr[MEM_IDX_W+OFS_W-1:OFS_W];
            wdata_q <= sram_req_i.wr_data;
            wmask_q <= sram_req_i.wr_mask;
        end
    end

    // write lands on the response edge, masked bytes only
    always_ff @(posedge clk) begin
        if (rsp_cycle && wr_q) begin
            for (int b = 0; b < BYTES; b++) begin
                if (wmask_q[b]) begin
                    mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        sram_rsp_o.rd_data_valid = rsp_cycle & rd_q;
        sram_rsp_o.wr_data_ok = rsp_cycle & wr_q;
        // whole doubleword, lsu picks the lane
        sram_rsp_o.rd_data = mem[idx_q];
    end

endmodule

//--- lsu_top.sv
`timescale 1ns/100ps

module lsu_top (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic [lsu_pkg::INST_LEN-1:0] instr_i,
    input  logic [lsu_pkg::XLEN-1:0]     addr_i,
    input  logic [lsu_pkg::XLEN-1:0]     rs2_i,
    output logic [lsu_pkg::XLEN-1:0]     ls_res_o,
    output logic                         ls_not_ok_o
);
    import lsu_pkg::*;

    // decoder to unit
    ls_req_t   ls_req;
    // unit to sram and back
    sram_req_t sram_req;
    sram_rsp_t sram_rsp;

    // result and stall level also feed the forwarding registers
    ls_decode i_ls_decode (
        .clk         (clk),
        .rstn        (rstn),
        .instr_i     (instr_i),
        .addr_i      (addr_i),
        .rs2_i       (rs2_i),
        .ls_res_i    (ls_res_o),
        .ls_not_ok_i (ls_not_ok_o),
        .ls_req_o    (ls_req)
    );

    lsu i_lsu (
        .clk         (clk),
        .rstn        (rstn),
        .ls_req_i    (ls_req),
        .sram_rsp_i  (sram_rsp),
        .sram_req_o  (sram_req),
        .ls_res_o    (ls_res_o),
        .ls_not_ok_o (ls_not_ok_o)
    );

    // fixed latency data memory
    data_sram i_data_sram (
        .clk        (clk),
        .rstn       (rstn),
        .sram_req_i (sram_req),
        .sram_rsp_o (sram_rsp)
    );

endmodule

//--- tb_lsu_top.sv
`timescale 1ns/100ps

module tb_lsu_top;
    import lsu_pkg::*;

    // addi x0, x0, 0 as the non-memory instruction
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam int REF_BYTES = MEM_WORDS * 8;

    // one table row: test id, instruction, address, rs2 value, result check
    typedef struct packed {
        logic [2:0]      tid;
        logic [31:0]     instr;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] rs2_val;
        logic            chk;
    } entry_t;

    logic            clk = 1'b0;
    logic            rstn;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] addr_i;
    logic [XLEN-1:0] rs2_i;
    logic [XLEN-1:0] ls_res_o;
    logic            ls_not_ok_o;

    entry_t          tbl[$];
    logic [XLEN-1:0] written[$];
    logic [7:0]      ref_mem [REF_BYTES];
    logic [31:0]     rng_state = 32'h30f9471b;

    // previous retired entry, for stall length and forwarding
    logic            prev_mem = 1'b0;
    logic            prev_ld = 1'b0;
    logic [4:0]      prev_rd = 5'd0;
    logic [XLEN-1:0] prev_ld_val = '0;

    int test_checks = 0;
    int test_errs = 0;
    int total_checks = 0;
    int total_errs = 0;
    int tests_done = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    lsu_top i_lsu_top (
        .clk         (clk),
        .rstn        (rstn),
        .instr_i     (instr_i),
        .addr_i      (addr_i),
        .rs2_i       (rs2_i),
        .ls_res_o    (ls_res_o),
        .ls_not_ok_o (ls_not_ok_o)
    );

    always #5 clk = ~clk;

    // run limit from table length
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: no access completed within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [63:0] next_rand();
        logic [31:0] hi;
        rng_state = xorshift32(rng_state);
        hi = rng_state;
        rng_state = xorshift32(rng_state);
        return {hi, rng_state};
    endfunction

    // i-type load, rs1 x1, imm 0
    function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [4:0] rd);
        return {12'h000, 5'd1, f3, rd, OP_LOAD};
    endfunction

    // s-type store, rs1 x1, imm 0
    function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [4:0] rs2);
        return {7'h00, rs2, 5'd1, f3, 5'h00, OP_STORE};
    endfunction

    // size from funct3[1:0], zero extension when funct3[2] is set
    function automatic logic [63:0] ref_load(input logic [63:0] addr, input logic [2:0] f3);
        int          size;
        logic [63:0] v;
        size = 1 << f3[1:0];
        v = '0;
        for (int i = 0; i < size; i++) begin
            v[8*i +: 8] = ref_mem[int'(addr[10:0]) + i];
        end
        if (!f3[2] && size < 8 && v[8*size-1]) begin
            v = v | ~((64'h1 << (8*size)) - 64'h1);
        end
        return v;
    endfunction

    // little-endian bytes from the low end of the data
    task automatic ref_store(input logic [63:0] addr, input logic [2:0] f3, input logic [63:0] d);
        int size;
        size = 1 << f3[1:0];
        for (int i = 0; i < size; i++) begin
            ref_mem[int'(addr[10:0]) + i] = d[8*i +: 8];
        end
    endtask

    task automatic add_entry(input int tid, input logic [31:0] instr, input logic [63:0] addr,
                             input logic [63:0] val, input logic chk);
        entry_t e;
        e.tid = 3'(tid);
        e.instr = instr;
        e.addr = addr;
        e.rs2_val = val;
        e.chk = chk;
        tbl.push_back(e);
    endtask

    task automatic add_load(input int tid, input logic [2:0] f3, input logic [4:0] rd,
                            input logic [63:0] addr);
        add_entry(tid, enc_load(f3, rd), addr, 64'h0, 1'b1);
    endtask

    // also remembers the doubleword for the final sweep
    task automatic add_store(input int tid, input logic [2:0] f3, input logic [4:0] rs2,
                             input logic [63:0] addr);
        logic [63:0] dw;
        logic        seen;
        add_entry(tid, enc_store(f3, rs2), addr, next_rand(), 1'b0);
        dw = {addr[63:3], 3'b000};
        seen = 1'b0;
        foreach (written[w]) begin
            if (written[w] == dw) seen = 1'b1;
        end
        if (!seen) written.push_back(dw);
    endtask

    task automatic build_table();
        logic [63:0] bases [4];
        bases = '{64'h000, 64'h108, 64'h3f0, 64'h7f8};
        // every width at every aligned offset
        foreach (bases[b]) begin
            add_store(2, MEMOP_SD, 5'd10, bases[b]);
            for (int o = 0; o < 8; o++) begin
                add_load(2, MEMOP_LB, 5'd11, bases[b] + 64'(o));
                add_load(2, MEMOP_LBU, 5'd11, bases[b] + 64'(o));
            end
            for (int o = 0; o < 8; o += 2) begin
                add_load(2, MEMOP_LH, 5'd11, bases[b] + 64'(o));
                add_load(2, MEMOP_LHU, 5'd11, bases[b] + 64'(o));
            end
            for (int o = 0; o < 8; o += 4) begin
                add_load(2, MEMOP_LW, 5'd11, bases[b] + 64'(o));
                add_load(2, MEMOP_LWU, 5'd11, bases[b] + 64'(o));
            end
            add_load(2, MEMOP_LD, 5'd11, bases[b]);
            add_entry(2, NOP_WORD, 64'h0, 64'h0, 1'b1);
        end
        // partial stores into a full doubleword
        add_store(3, MEMOP_SD, 5'd10, 64'h200);
        add_store(3, MEMOP_SB, 5'd10, 64'h203);
        add_store(3, MEMOP_SH, 5'd10, 64'h206);
        add_load(3, MEMOP_LD, 5'd11, 64'h200);
        add_store(3, MEMOP_SW, 5'd10, 64'h204);
        add_load(3, MEMOP_LD, 5'd11, 64'h200);
        add_store(3, MEMOP_SD, 5'd10, 64'h240);
        add_store(3, MEMOP_SW, 5'd10, 64'h240);
        add_store(3, MEMOP_SB, 5'd10, 64'h247);
        add_store(3, MEMOP_SH, 5'd10, 64'h244);
        add_entry(3, NOP_WORD, 64'h0, 64'h0, 1'b1);
        add_load(3, MEMOP_LD, 5'd11, 64'h240);
        add_load(3, MEMOP_LW, 5'd11, 64'h244);
        // load result into the very next store
        add_store(4, MEMOP_SD, 5'd10, 64'h300);
        add_store(4, MEMOP_SD, 5'd10, 64'h310);
        add_load(4, MEMOP_LD, 5'd5, 64'h300);
        add_store(4, MEMOP_SD, 5'd5, 64'h308);
        add_load(4, MEMOP_LD, 5'd11, 64'h308);
        add_load(4, MEMOP_LW, 5'd7, 64'h304);
        add_store(4, MEMOP_SW, 5'd7, 64'h310);
        add_load(4, MEMOP_LD, 5'd11, 64'h310);
        add_load(4, MEMOP_LHU, 5'd8, 64'h302);
        add_store(4, MEMOP_SD, 5'd8, 64'h318);
        add_load(4, MEMOP_LD, 5'd11, 64'h318);
        // register mismatch, then a gap, both take rs2_i
        add_load(4, MEMOP_LD, 5'd5, 64'h300);
        add_store(4, MEMOP_SD, 5'd6, 64'h320);
        add_load(4, MEMOP_LD, 5'd11, 64'h320);
        add_load(4, MEMOP_LD, 5'd5, 64'h300);
        add_entry(4, NOP_WORD, 64'h0, 64'h0, 1'b1);
        add_store(4, MEMOP_SD, 5'd5, 64'h328);
        add_load(4, MEMOP_LD, 5'd11, 64'h328);
        // back-to-back accesses, then read back everything written
        for (int i = 0; i < 8; i++) add_store(5, MEMOP_SD, 5'd10, 64'h400 + 64'(8*i));
        for (int i = 0; i < 8; i++) add_load(5, MEMOP_LD, 5'd11, 64'h400 + 64'(8*i));
        add_store(5, MEMOP_SB, 5'd10, 64'h401);
        add_store(5, MEMOP_SH, 5'd10, 64'h40a);
        add_store(5, MEMOP_SW, 5'd10, 64'h414);
        foreach (written[w]) add_load(5, MEMOP_LD, 5'd11, written[w]);
    endtask

    task automatic check_idle(input string when_s);
        test_checks++;
        assert (ls_not_ok_o === 1'b0 && ls_res_o === '0) else begin
            $display("FAIL t=%0t %s: ls_not_ok_o=%b ls_res_o=%h", $time, when_s,
                     ls_not_ok_o, ls_res_o);
            test_errs++;
        end
    endtask

    function automatic string test_name(input int tid);
        case (tid)
            1: return "reset state";
            2: return "width and extension";
            3: return "byte-masked merge";
            4: return "load-to-store forwarding";
            default: return "stall and completion";
        endcase
    endfunction

    task automatic finish_test(input int tid);
        $display("test %0d %s: %0d checks, %0d errors", tid, test_name(tid), test_checks,
                 test_errs);
        total_checks += test_checks;
        total_errs += test_errs;
        tests_done++;
        test_checks = 0;
        test_errs = 0;
    endtask

    // present one row, wait for completion, check, update the model
    task automatic run_entry(input int k);
        entry_t          e;
        logic            is_ld;
        logic            is_st;
        logic [2:0]      f3;
        logic [XLEN-1:0] exp_res;
        int              waits;
        int              exp_waits;
        e = tbl[k];
        f3 = e.instr[14:12];
        is_ld = (e.instr[6:0] == OP_LOAD);
        is_st = (e.instr[6:0] == OP_STORE);
        instr_i = e.instr;
        addr_i = e.addr;
        rs2_i = e.rs2_val;
        // first cycle after a completion is masked
        exp_waits = (is_ld || is_st) ? (prev_mem ? SRAM_LAT + 1 : SRAM_LAT) : 0;
        waits = 0;
        @(negedge clk);
        while (ls_not_ok_o !== 1'b0) begin
            waits++;
            @(negedge clk);
        end
        test_checks++;
        assert (waits == exp_waits) else begin
            $display("FAIL t=%0t entry %0d: stalled %0d cycles, expected %0d", $time, k,
                     waits, exp_waits);
            test_errs++;
        end
        exp_res = is_ld ? ref_load(e.addr, f3) : '0;
        if (e.chk) begin
            test_checks++;
            assert (ls_res_o === exp_res) else begin
                $display("FAIL t=%0t entry %0d: ls_res_o %h, expected %h", $time, k,
                         ls_res_o, exp_res);
                test_errs++;
            end
        end
        // a store right after a load of its rs2 takes the loaded value
        if (is_st) begin
            if (prev_ld && prev_rd == e.instr[24:20]) ref_store(e.addr, f3, prev_ld_val);
            else ref_store(e.addr, f3, e.rs2_val);
        end
        prev_mem = is_ld || is_st;
        prev_ld = is_ld;
        prev_rd = e.instr[11:7];
        prev_ld_val = exp_res;
    endtask

    initial begin
        rstn = 1'b0;
        instr_i = NOP_WORD;
        addr_i = '0;
        rs2_i = '0;
        build_table();
        cycle_limit = tbl.size() * (SRAM_LAT + 3) + 20;
        @(negedge clk);
        check_idle("during reset");
        @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_idle("after reset");
        finish_test(1);
        for (int k = 0; k < tbl.size(); k++) begin
            @(posedge clk);
            #1;
            run_entry(k);
            if (k == tbl.size() - 1 || tbl[k+1].tid != tbl[k].tid) finish_test(int'(tbl[k].tid));
        end
        $display("%0d tests, %0d checks, %0d errors", tests_done, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- flist.f
lsu_pkg.sv
ls_decode.sv
lsu.sv
data_sram.sv
lsu_top.sv
tb_lsu_top.sv

//--- Makefile
# Verilator build and run of the lsu testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_top -f flist.f
	./obj_dir/Vtb_lsu_top | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module tb_lsu_top -f flist.f

clean:
	rm -rf obj_dir sim.log
